/* Bender.yml */
package:
  name: i2c_target

sources:
  - source/i2cPkg.sv
  - source/i2cLineSync.sv
  - source/i2cByteShifter.sv
  - source/i2cTargetFsm.sv
  - source/regBank.sv
  - source/i2cTarget.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/tbI2cTarget.sv

/* list.f */
source/i2cPkg.sv
source/i2cLineSync.sv
source/i2cByteShifter.sv
source/i2cTargetFsm.sv
source/regBank.sv
source/i2cTarget.sv
test/clockGen.sv
test/tbI2cTarget.sv

/* source/i2cByteShifter.sv */
// I2C byte shifter
// Receives a byte MSB first on SCL rises, or sends one MSB first
// on SCL falls; flags the eighth bit of every byte

`timescale 1ns/100ps

module i2cByteShifter (
	input  logic              CLK,
	input  logic              rstN,
	input  i2cPkg::busEventsT events,
	input  i2cPkg::shiftCmdT  cmd,
	output logic [7:0]        rxByte,
	output logic              byteDone,
	output logic              txBit
);
	import i2cPkg::*;

	logic [7:0] shiftReg;                        // Received bits, or bits still to send
	logic [2:0] bitCount;                        // SCL rises seen in this byte

	// Bit counter runs on SCL rises in both directions
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			bitCount <= '0;
		end else if (cmd.clear || cmd.load) begin
			bitCount <= '0;                      // New byte starts
		end else if (events.sclRise) begin
			bitCount <= bitCount + 3'd1;         // Wraps after the eighth bit
		end
	end

	// Shift register
	always_ff @(posedge CLK) begin
		if (cmd.load) begin
			shiftReg <= {cmd.txByte[6:0], 1'b1}; // MSB goes out through txBit now
		end else if (cmd.txEnable && events.sclFall) begin
			shiftReg <= {shiftReg[6:0], 1'b1};   // Next bit to MSB, fill with released level
		end else if (!cmd.txEnable && events.sclRise) begin
			shiftReg <= {shiftReg[6:0], events.sda};  // Sample on SCL high
		end
	end

	// Eighth rise of the byte
	assign byteDone = events.sclRise && (bitCount == 3'd7);

	// Complete byte on the byteDone cycle, last bit taken straight from the line
	assign rxByte = {shiftReg[6:0], events.sda};

	// Bit for the FSM to drive at this SCL fall
	assign txBit = cmd.load ? cmd.txByte[7] : shiftReg[7];

endmodule

/* source/i2cLineSync.sv */
// I2C line synchronizer
// Brings SCL and SDA into the clock domain, then reports SCL edges
// and START and STOP conditions as one-cycle pulses

`timescale 1ns/100ps

module i2cLineSync (
	input  logic              CLK,
	input  logic              rstN,
	input  logic              scl,
	input  logic              sdaIn,
	output i2cPkg::busEventsT events
);
	import i2cPkg::*;

	logic [syncStages-1:0] sclSync;              // SCL synchronizer chain
	logic [syncStages-1:0] sdaSync;              // SDA synchronizer chain
	logic                  sclPrev;              // Last synchronized SCL
	logic                  sdaPrev;              // Last synchronized SDA
	logic                  sclNow;
	logic                  sdaNow;

	assign sclNow = sclSync[syncStages-1];       // Output of the last stage
	assign sdaNow = sdaSync[syncStages-1];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			sclSync <= '1;                       // Idle bus reads high
			sdaSync <= '1;
			sclPrev <= 1'b1;
			sdaPrev <= 1'b1;
			events  <= '{sclRise: 1'b0, sclFall: 1'b0, start: 1'b0, stop: 1'b0, sda: 1'b1};
		end else begin
			sclSync <= {sclSync[syncStages-2:0], scl};
			sdaSync <= {sdaSync[syncStages-2:0], sdaIn};
			sclPrev <= sclNow;
			sdaPrev <= sdaNow;

			// Edge detect stage, third cycle of latency
			events.sclRise <= sclNow & ~sclPrev;
			events.sclFall <= ~sclNow & sclPrev;
			events.start   <= sclNow & sclPrev & sdaPrev & ~sdaNow;  // SDA falls, SCL high
			events.stop    <= sclNow & sclPrev & ~sdaPrev & sdaNow;  // SDA rises, SCL high
			events.sda     <= sdaNow;            // Level aligned with the pulses
		end
	end

endmodule

/* source/i2cPkg.sv */
// I2C register target shared definitions
// Word, address and ID types, the bus event and shifter command
// bundles, the register request and the FSM state encoding

package i2cPkg;

	// Register word and address as seen on the bus
	typedef logic [15:0] regDataT;                // One 16-bit register
	typedef logic [15:0] regAddrT;                // Address, high byte first on the bus
	typedef logic [6:0]  devIdT;                  // 7-bit target ID

	// Bank layout
	localparam int regCount = 16;                 // Registers in the bank
	localparam int regIdxW = $clog2(regCount);    // Index bits for the bank
	localparam int idRegAddr = 4;                 // Register holding the device ID
	localparam devIdT defaultDevId = 7'h28;       // ID after reset

	// Line synchronizer depth
	localparam int syncStages = 2;

	// Events from the line synchronizer, all one-cycle pulses except sda
	typedef struct packed {
		logic sclRise;                            // SCL went high
		logic sclFall;                            // SCL went low
		logic start;                              // SDA fell with SCL high
		logic stop;                               // SDA rose with SCL high
		logic sda;                                // Synchronized SDA level
	} busEventsT;

	// Request to the register bank
	typedef struct packed {
		logic    valid;                           // Request active
		logic    write;                           // 1 write, 0 read
		regAddrT addr;                            // Register address
		regDataT wdata;                           // Write word
	} regReqT;

	// Command from the FSM to the byte shifter
	typedef struct packed {
		logic       clear;                        // Restart bit count
		logic       load;                         // Capture txByte, present its MSB
		logic       txEnable;                     // Shift out on SCL fall
		logic [7:0] txByte;                       // Byte to send
	} shiftCmdT;

	// Transaction states
	typedef enum logic [3:0] {
		idle,                                     // Waiting for START
		devAddr,                                  // Receiving ID and R/W bit
		devAck,                                   // ACK slot after ID
		addrByte,                                 // Receiving register address byte
		addrAck,                                  // ACK slot after address byte
		writeByte,                                // Receiving data byte
		writeAck,                                 // ACK slot after data byte
		readByte,                                 // Sending data byte
		readAck,                                  // Master ACK slot
		waitStop                                  // Released, waiting for STOP
	} targetStateT;

endpackage

/* source/i2cTarget.sv */
// I2C register target top level
// Line synchronizer, byte shifter, protocol FSM and register bank;
// sdaOut 0 pulls the line low, 1 releases it

`timescale 1ns/100ps

module i2cTarget (
	input  logic CLK,
	input  logic rstN,
	input  logic scl,
	input  logic sdaIn,
	output logic sdaOut
);
	import i2cPkg::*;

	busEventsT  events;                          // Synchronized bus events
	shiftCmdT   cmd;                             // FSM to shifter
	regReqT     regReq;                          // FSM to bank
	regDataT    rdData;
	devIdT      devId;
	logic [7:0] rxByte;
	logic       byteDone;
	logic       txBit;

	i2cLineSync lineSync (
		.CLK    (CLK),
		.rstN   (rstN),
		.scl    (scl),
		.sdaIn  (sdaIn),
		.events (events)
	);

	i2cByteShifter byteShifter (
		.CLK      (CLK),
		.rstN     (rstN),
		.events   (events),
		.cmd      (cmd),
		.rxByte   (rxByte),
		.byteDone (byteDone),
		.txBit    (txBit)
	);

	i2cTargetFsm targetFsm (
		.CLK      (CLK),
		.rstN     (rstN),
		.events   (events),
		.rxByte   (rxByte),
		.byteDone (byteDone),
		.txBit    (txBit),
		.devId    (devId),
		.rdData   (rdData),
		.cmd      (cmd),
		.regReq   (regReq),
		.sdaOut   (sdaOut)
	);

	regBank bank (
		.CLK    (CLK),
		.rstN   (rstN),
		.regReq (regReq),
		.rdData (rdData),
		.devId  (devId)
	);

endmodule

/* source/i2cTargetFsm.sv */
// I2C target protocol FSM
// Matches the device ID, collects two register address bytes, then
// receives or sends one 16-bit word; drives the ACK slots and issues
// read and write requests to the register bank

`timescale 1ns/100ps

module i2cTargetFsm (
	input  logic              CLK,
	input  logic              rstN,
	input  i2cPkg::busEventsT events,
	input  logic [7:0]        rxByte,
	input  logic              byteDone,
	input  logic              txBit,
	input  i2cPkg::devIdT     devId,
	input  i2cPkg::regDataT   rdData,
	output i2cPkg::shiftCmdT  cmd,
	output i2cPkg::regReqT    regReq,
	output logic              sdaOut
);
	import i2cPkg::*;

	targetStateT state;
	targetStateT ackExit;                        // State after the current ACK slot
	logic        isRead;                         // R/W bit of the address byte
	logic        addrLow;                        // Second address byte in progress
	logic        dataLow;                        // Second data byte in progress
	logic        slotOn;                         // ACK slot clock pulse under way
	logic        mAck;                           // Master ACKed the sent byte
	logic        wrPulse;                        // One-cycle write request
	logic        rdReq;
	logic        ackState;
	regAddrT     regAddr;                        // Collected register address
	regDataT     wdata;                          // Collected write word
	logic [7:0]  rdLow;                          // Low read byte kept for the second send

	assign ackState = (state == devAck) || (state == addrAck) ||
		(state == writeAck) || (state == readAck);

	// Where each ACK slot leads
	always_comb begin
		case (state)
			devAck:   ackExit = addrByte;
			addrAck:  ackExit = !addrLow ? addrByte : (isRead ? readByte : writeByte);
			writeAck: ackExit = dataLow ? waitStop : writeByte;
			readAck:  ackExit = (!dataLow && mAck) ? readByte : waitStop;  // NACK ends it
			default:  ackExit = waitStop;
		endcase
	end

	// Shifter control
	always_comb begin
		cmd.clear    = events.start || (events.sclFall && slotOn);  // Byte boundary
		cmd.load     = events.sclFall && slotOn && (ackExit == readByte);
		cmd.txEnable = (state == readByte) || (state == readAck);
		cmd.txByte   = (state == readAck) ? rdLow : rdData[15:8];   // High byte first
	end

	// Read held through the address ACK slot, write is the single pulse
	assign rdReq = (state == addrAck) && addrLow && isRead;
	assign regReq = '{valid: rdReq || wrPulse, write: wrPulse, addr: regAddr, wdata: wdata};

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state   <= idle;
			sdaOut  <= 1'b1;                     // Line released
			isRead  <= 1'b0;
			addrLow <= 1'b0;
			dataLow <= 1'b0;
			slotOn  <= 1'b0;
			mAck    <= 1'b0;
			wrPulse <= 1'b0;
		end else begin
			wrPulse <= 1'b0;
			if (events.start) begin              // Restart from any state
				state   <= devAddr;
				sdaOut  <= 1'b1;
				addrLow <= 1'b0;
				dataLow <= 1'b0;
				slotOn  <= 1'b0;
			end else if (events.stop) begin
				state  <= idle;
				sdaOut <= 1'b1;
				slotOn <= 1'b0;
			end else if (ackState) begin
				if (state == readAck && events.sclRise && slotOn) begin
					mAck <= ~events.sda;         // Low means ACK
				end
				if (events.sclFall && !slotOn) begin
					slotOn <= 1'b1;
					sdaOut <= (state == readAck);  // Pull low, or release for the master
				end else if (events.sclFall) begin
					slotOn <= 1'b0;
					sdaOut <= cmd.load ? txBit : 1'b1;  // First data bit or release
					state  <= ackExit;
					if (state == addrAck) begin
						addrLow <= 1'b1;
					end
					if (state == writeAck || state == readAck) begin
						dataLow <= 1'b1;
					end
				end
			end else begin
				case (state)
					devAddr: begin
						if (byteDone) begin
							if (rxByte[7:1] == devId) begin
								isRead <= rxByte[0];
								state  <= devAck;
							end else begin
								state <= waitStop;  // Not ours, stay off the line
							end
						end
					end
					addrByte: begin
						if (byteDone) begin
							state <= addrAck;
						end
					end
					writeByte: begin
						if (byteDone) begin
							wrPulse <= dataLow;  // Word complete after low byte
							state   <= writeAck;
						end
					end
					readByte: begin
						if (events.sclFall) begin
							sdaOut <= txBit;
						end
						if (byteDone) begin
							state <= readAck;
						end
					end
					default: ;                   // idle and waitStop hold
				endcase
			end
		end
	end

	// Address, write word and read low byte
	always_ff @(posedge CLK) begin
		if (byteDone && state == addrByte) begin
			if (addrLow) begin
				regAddr[7:0] <= rxByte;
			end else begin
				regAddr[15:8] <= rxByte;
			end
		end
		if (byteDone && state == writeByte) begin
			if (dataLow) begin
				wdata[7:0] <= rxByte;
			end else begin
				wdata[15:8] <= rxByte;
			end
		end
		if (cmd.load && state == addrAck) begin
			rdLow <= rdData[7:0];                // Bank read is valid in this slot
		end
	end

endmodule

/* source/regBank.sv */
// Register bank for the I2C target
// Sixteen 16-bit registers with decoded access; register 4 holds
// the device ID that the target answers to

`timescale 1ns/100ps

module regBank (
	input  logic            CLK,
	input  logic            rstN,
	input  i2cPkg::regReqT  regReq,
	output i2cPkg::regDataT rdData,
	output i2cPkg::devIdT   devId
);
	import i2cPkg::*;

	regDataT             regs [regCount];        // Register storage
	logic                hit;                    // Address inside the bank
	logic [regIdxW-1:0]  idx;                    // Decoded register index

	assign hit = regReq.addr < regAddrT'(regCount);
	assign idx = regReq.addr[regIdxW-1:0];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				if (i == idRegAddr) begin
					regs[i] <= regDataT'(defaultDevId);  // Target answers here after reset
				end else begin
					regs[i] <= '0;
				end
			end
		end else if (regReq.valid && regReq.write && hit) begin
			regs[idx] <= regReq.wdata;           // Out of range writes dropped
		end
	end

	// Reads are combinational and always ready
	assign rdData = hit ? regs[idx] : '0;

	// ID follows the register, so a write moves the target at once
	assign devId = regs[idRegAddr][$bits(devIdT)-1:0];

endmodule

/* test/clockGen.sv */
// Testbench clock and reset
// 20 ns clock, reset held low for the first two cycles

`timescale 1ns/100ps

module clockGen (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;                  // 20 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge CLK);
		rstN <= 1'b1;                            // Release after two edges
	end

endmodule

/* test/tbI2cTarget.sv */
// I2C register target testbench
// Bus master with an open-drain SDA model, directed tests for ID match,
// register write and read, ID change, out of range access and random words

`timescale 1ns/100ps

module tbI2cTarget;
	import i2cPkg::*;

	localparam int quarter = 4;                  // Clock cycles per quarter SCL period
	localparam int txnCount = 43;                // Transactions over all tests
	localparam int bitsPerTxn = 50;              // Five 9-bit bytes, START, STOP, idle
	localparam int timeoutCycles = txnCount * bitsPerTxn * 16 * 2;

	logic    CLK;
	logic    rstN;
	logic    scl;
	logic    sdaDrv;                             // Master side of SDA
	logic    sdaOut;
	logic    sdaLine;
	int      errCount;
	int      checkCount;
	int      cycleCount;
	int      seedDummy;
	regDataT regModel [regCount];                // Expected bank contents

	assign sdaLine = sdaDrv & sdaOut;            // Open-drain wired-AND

	clockGen clkGen (.CLK(CLK), .rstN(rstN));

	i2cTarget UUT (
		.CLK    (CLK),
		.rstN   (rstN),
		.scl    (scl),
		.sdaIn  (sdaLine),
		.sdaOut (sdaOut)
	);

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	task automatic checkWord(input string name, input regDataT got, input regDataT exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
		end
	endtask

	task automatic checkAck(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// One SCL clock with SCL low on entry and on exit
	task automatic clockBit(input logic bitVal, output logic lineVal);
		waitCycles(quarter);
		sdaDrv <= bitVal;                        // Data changes mid low phase
		waitCycles(quarter);
		scl <= 1'b1;
		waitCycles(quarter);
		@(negedge CLK);
		lineVal = sdaLine;                       // Middle of the high phase
		waitCycles(quarter);
		scl <= 1'b0;
	endtask

	task automatic startCond();
		waitCycles(2 * quarter);                 // Bus idle first
		sdaDrv <= 1'b0;                          // SDA falls with SCL high
		waitCycles(2 * quarter);
		scl <= 1'b0;
	endtask

	task automatic stopCond();
		waitCycles(quarter);
		sdaDrv <= 1'b0;
		waitCycles(quarter);
		scl <= 1'b1;
		waitCycles(2 * quarter);
		sdaDrv <= 1'b1;                          // SDA rises with SCL high
		waitCycles(2 * quarter);
	endtask

	// Ninth clock of a byte where a low line is an ACK
	task automatic ackSlot(input logic bitVal, output logic acked);
		logic lineVal;
		clockBit(bitVal, lineVal);
		acked = ~lineVal;
	endtask

	task automatic sendByte(input logic [7:0] data, output logic acked);
		logic lineVal;
		for (int i = 7; i >= 0; i--) begin
			clockBit(data[i], lineVal);          // MSB first
		end
		ackSlot(1'b1, acked);                    // Released for the target
	endtask

	task automatic recvByte(input logic giveAck, output logic [7:0] data);
		logic lineVal;
		logic unused;
		for (int i = 7; i >= 0; i--) begin
			clockBit(1'b1, lineVal);
			data[i] = lineVal;
		end
		ackSlot(~giveAck, unused);
	endtask

	task automatic writeReg(input devIdT id, input regAddrT addr, input regDataT data,
			input logic expAck);
		logic acked;
		startCond();
		sendByte({id, 1'b0}, acked);
		checkAck("ID ACK", acked, expAck);
		if (acked) begin
			sendByte(addr[15:8], acked);
			checkAck("address high ACK", acked, 1'b1);
			sendByte(addr[7:0], acked);
			checkAck("address low ACK", acked, 1'b1);
			sendByte(data[15:8], acked);
			checkAck("data high ACK", acked, 1'b1);
			sendByte(data[7:0], acked);
			checkAck("data low ACK", acked, 1'b1);
		end
		stopCond();
	endtask

	task automatic readReg(input devIdT id, input regAddrT addr, input logic expAck,
			output regDataT data);
		logic       acked;
		logic [7:0] hiByte;
		logic [7:0] loByte;
		hiByte = 8'h00;
		loByte = 8'h00;
		startCond();
		sendByte({id, 1'b1}, acked);
		checkAck("ID ACK", acked, expAck);
		if (acked) begin
			sendByte(addr[15:8], acked);
			checkAck("address high ACK", acked, 1'b1);
			sendByte(addr[7:0], acked);
			checkAck("address low ACK", acked, 1'b1);
			recvByte(1'b1, hiByte);
			recvByte(1'b0, loByte);              // NACK ends the read
		end
		stopCond();
		data = {hiByte, loByte};
	endtask

	task automatic resetTest();
		regDataT data;
		@(negedge CLK);
		checkAck("sdaOut", sdaOut, 1'b1);        // Line released after reset
		readReg(7'h28, 16'd4, 1'b1, data);
		checkWord("reg[4]", data, 16'h0028);
	endtask

	task automatic writeReadTest();
		regDataT data;
		writeReg(7'h28, 16'd2, 16'hA5C3, 1'b1);
		regModel[2] = 16'hA5C3;
		readReg(7'h28, 16'd2, 1'b1, data);
		checkWord("reg[2]", data, regModel[2]);
	endtask

	task automatic wrongIdTest();
		regDataT data;
		writeReg(7'h33, 16'd2, 16'h1111, 1'b0);  // Not ours, no ACK
		readReg(7'h28, 16'd2, 1'b1, data);
		checkWord("reg[2]", data, regModel[2]);
	endtask

	task automatic idMoveTest();
		regDataT data;
		writeReg(7'h28, 16'd4, 16'h0055, 1'b1);  // Target moves to 7'h55
		regModel[4] = 16'h0055;
		readReg(7'h28, 16'd4, 1'b0, data);
		readReg(7'h55, 16'd4, 1'b1, data);
		checkWord("reg[4]", data, 16'h0055);
		writeReg(7'h55, 16'd7, 16'h7E81, 1'b1);
		regModel[7] = 16'h7E81;
		readReg(7'h55, 16'd7, 1'b1, data);
		checkWord("reg[7]", data, regModel[7]);
		writeReg(7'h55, 16'd4, 16'h0028, 1'b1);  // Back to the reset ID
		regModel[4] = 16'h0028;
		readReg(7'h28, 16'd4, 1'b1, data);
		checkWord("reg[4]", data, 16'h0028);
	endtask

	task automatic outOfRangeTest();
		regDataT data;
		writeReg(7'h28, 16'd3, 16'h3C96, 1'b1);  // Same low bits as 16'h0123
		regModel[3] = 16'h3C96;
		readReg(7'h28, 16'h0123, 1'b1, data);
		checkWord("reg[0x0123]", data, 16'h0000);
		writeReg(7'h28, 16'h0123, 16'hBEEF, 1'b1);  // Must land nowhere
		for (int i = 0; i < regCount; i++) begin
			readReg(7'h28, regAddrT'(i), 1'b1, data);
			checkWord($sformatf("reg[%0d]", i), data, regModel[i]);
		end
	endtask

	task automatic randomTest();
		int      picks [6];
		regDataT word;
		regDataT data;
		for (int k = 0; k < 6; k++) begin
			picks[k] = $urandom % 15;
			if (picks[k] >= 4) begin
				picks[k]++;                      // Skip the ID register
			end
			word = regDataT'($urandom);
			writeReg(7'h28, regAddrT'(picks[k]), word, 1'b1);
			regModel[picks[k]] = word;
		end
		for (int k = 0; k < 6; k++) begin
			readReg(7'h28, regAddrT'(picks[k]), 1'b1, data);
			checkWord($sformatf("reg[%0d]", picks[k]), data, regModel[picks[k]]);
		end
	endtask

	initial begin
		scl = 1'b1;                              // Idle bus
		sdaDrv = 1'b1;
		errCount = 0;
		checkCount = 0;
		cycleCount = 0;
		seedDummy = $urandom(32'h0470_9bac);
		for (int i = 0; i < regCount; i++) begin
			regModel[i] = 16'h0000;
		end
		regModel[4] = 16'h0028;                  // Reset ID register
		wait (rstN === 1'b1);
		waitCycles(2);
		resetTest();
		writeReadTest();
		wrongIdTest();
		idMoveTest();
		outOfRangeTest();
		randomTest();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
